// File: verilog/rename_pkg.sv
package rename_pkg;

    // register file sizes
    localparam int ARCH_W   = 5;    // architectural register number
    localparam int NUM_ARCH = 32;
    localparam int PHYS_W   = 7;    // physical tag, up to 128 registers

    // ALU and LOAD write a destination, STORE and BRANCH do not
    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,
        OP_LOAD   = 2'd1,
        OP_STORE  = 2'd2,
        OP_BRANCH = 2'd3
    } op_t;

    // shared by the four-phase side of intake, issue and free list
    typedef enum logic [1:0] {
        HS_IDLE = 2'd0,
        HS_BUSY = 2'd1,
        HS_DONE = 2'd2
    } hs_state_t;

    // decoded instruction as it arrives from the decoder, 17 bits
    typedef struct packed {
        op_t               op;
        logic [ARCH_W-1:0] src1;
        logic [ARCH_W-1:0] src2;
        logic [ARCH_W-1:0] dest;
    } arch_instr_t;

    // lookup request into the map table
    typedef struct packed {
        logic [ARCH_W-1:0] src1;
        logic [ARCH_W-1:0] src2;
        logic [ARCH_W-1:0] dest;
        logic              wr;     // instruction writes dest
    } rename_req_t;

    // renamed instruction, 30 bits
    // dest_tag and old_tag read 0 for instructions that write nothing
    typedef struct packed {
        op_t               op;
        logic [PHYS_W-1:0] src1_tag;
        logic [PHYS_W-1:0] src2_tag;
        logic [PHYS_W-1:0] dest_tag;
        logic [PHYS_W-1:0] old_tag;
    } renamed_t;

endpackage

// File: verilog/decode_intake.sv
`timescale 1ns/1ps

module decode_intake (
    input  logic                   clk,
    input  logic                   reset,

    // four-phase decode link
    input  logic                   dec_req,
    input  rename_pkg::arch_instr_t dec_instr,
    output logic                   dec_ack,

    // stream towards the rename stage
    output logic                   in_valid,
    output rename_pkg::arch_instr_t in_instr,
    input  logic                   in_ready
);

    rename_pkg::hs_state_t state;
    logic                  full;        // one-entry buffer holds an item
    logic                  capture;
    logic                  take;

    // new request only when the link is idle and the buffer has room
    assign capture = (state == rename_pkg::HS_IDLE) && dec_req && !full;
    assign take    = full && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rename_pkg::HS_IDLE;
        end else begin
            case (state)
                rename_pkg::HS_IDLE: begin
                    if (capture) state <= rename_pkg::HS_BUSY;   // ack rises here
                end
                rename_pkg::HS_BUSY: begin
                    if (!dec_req) state <= rename_pkg::HS_IDLE;  // decoder let go
                end
                default: state <= rename_pkg::HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (capture) begin
            full <= 1'b1;
        end else if (take) begin
            full <= 1'b0;
        end
    end

    // payload, only meaningful while full
    always_ff @(posedge clk) begin
        if (capture) in_instr <= dec_instr;
    end

    assign dec_ack  = (state == rename_pkg::HS_BUSY);
    assign in_valid = full;

endmodule

// File: verilog/map_table.sv
`timescale 1ns/1ps

module map_table #(
    parameter int NUM_PHYS = 48
) (
    input  logic                             clk,
    input  logic                             reset,
    input  rename_pkg::rename_req_t          rd,
    input  logic [rename_pkg::PHYS_W-1:0]    new_tag,
    input  logic                             wr_en,     // stage commits this instruction
    output logic [rename_pkg::PHYS_W-1:0]    src1_tag,
    output logic [rename_pkg::PHYS_W-1:0]    src2_tag,
    output logic [rename_pkg::PHYS_W-1:0]    old_tag
);

    typedef logic [rename_pkg::PHYS_W-1:0] tag_t;

    tag_t map_q [rename_pkg::NUM_ARCH];
    logic do_write;

    // the tag width caps the physical file at 128, and at least one tag
    // must be left over after the identity map
    if (NUM_PHYS < 33 || NUM_PHYS > 128) begin : g_bad_num_phys
        $error("map_table: NUM_PHYS %0d out of range 33..128", NUM_PHYS);
    end

    // r0 stays pinned to tag 0
    assign do_write = wr_en && rd.wr && (rd.dest != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::NUM_ARCH; i++) begin
                map_q[i] <= tag_t'(i);     // identity map
            end
        end else if (do_write) begin
            map_q[rd.dest] <= new_tag;
        end
    end

    // reads see the map before this cycle's write
    always_comb begin
        src1_tag = map_q[rd.src1];
        src2_tag = map_q[rd.src2];
        old_tag  = map_q[rd.dest];
    end

endmodule

// File: verilog/free_list.sv
`timescale 1ns/1ps

module free_list #(
    parameter int NUM_PHYS = 48
) (
    input  logic                             clk,
    input  logic                             reset,

    // allocation side, used by the rename stage
    input  logic                             pop,
    output logic [rename_pkg::PHYS_W-1:0]    free_tag,
    output logic                             empty,

    // four-phase retire link from the reorder buffer
    input  logic                             ret_req,
    input  logic [rename_pkg::PHYS_W-1:0]    ret_tag,
    output logic                             ret_ack
);

    localparam int DEPTH = NUM_PHYS - rename_pkg::NUM_ARCH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [rename_pkg::PHYS_W-1:0] tag_t;
    typedef logic [PTR_W-1:0]              ptr_t;

    tag_t                  q [DEPTH];
    ptr_t                  head;        // oldest free tag
    ptr_t                  tail;        // next slot for a returned tag
    logic [CNT_W-1:0]      count;
    rename_pkg::hs_state_t state;

    logic full;
    logic ret_seen;
    logic push_en;
    logic pop_en;

    function automatic ptr_t next_ptr(input ptr_t p);
        next_ptr = (p == ptr_t'(DEPTH - 1)) ? '0 : p + ptr_t'(1);
    endfunction

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign ret_seen = (state == rename_pkg::HS_IDLE) && ret_req;
    assign push_en  = ret_seen && (ret_tag != '0) && !full;   // tag 0 is acked but dropped
    assign pop_en   = pop && !empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                q[i] <= tag_t'(rename_pkg::NUM_ARCH + i);
            end
            head  <= '0;
            tail  <= '0;                 // queue starts full, tail wrapped onto head
            count <= CNT_W'(DEPTH);
        end else begin
            if (push_en) begin
                q[tail] <= ret_tag;
                tail    <= next_ptr(tail);
            end
            if (pop_en) head <= next_ptr(head);
            case ({push_en, pop_en})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // retire handshake
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rename_pkg::HS_IDLE;
        end else begin
            case (state)
                rename_pkg::HS_IDLE: if (ret_seen) state <= rename_pkg::HS_BUSY;
                rename_pkg::HS_BUSY: if (!ret_req) state <= rename_pkg::HS_IDLE;
                default:             state <= rename_pkg::HS_IDLE;
            endcase
        end
    end

    assign ret_ack  = (state == rename_pkg::HS_BUSY);
    assign free_tag = q[head];   // head entry is never the one written this cycle

endmodule

// File: verilog/rename_stage.sv
`timescale 1ns/1ps

module rename_stage #(
    parameter int NUM_PHYS = 48
) (
    input  logic                             clk,
    input  logic                             reset,

    // from decode_intake
    input  logic                             in_valid,
    input  rename_pkg::arch_instr_t          in_instr,
    output logic                             in_ready,

    // to rename_issue
    output logic                             out_valid,
    output rename_pkg::renamed_t             out_data,
    input  logic                             out_ready,

    // free list allocation
    output logic                             pop,
    input  logic [rename_pkg::PHYS_W-1:0]    free_tag,
    input  logic                             empty
);

    rename_pkg::rename_req_t        rd;
    logic [rename_pkg::PHYS_W-1:0]  src1_tag;
    logic [rename_pkg::PHYS_W-1:0]  src2_tag;
    logic [rename_pkg::PHYS_W-1:0]  old_tag;
    logic                           writes;
    logic                           can_go;     // no tag needed, or one is there
    logic                           fire;

    // only ALU and LOAD to a nonzero register need a new tag
    always_comb begin
        case (in_instr.op)
            rename_pkg::OP_ALU,
            rename_pkg::OP_LOAD: writes = (in_instr.dest != '0);
            default:             writes = 1'b0;
        endcase
    end

    assign can_go    = !writes || !empty;
    assign out_valid = in_valid && can_go;
    assign in_ready  = out_ready && can_go;
    assign fire      = in_valid && in_ready;   // transfer, map write and pop together
    assign pop       = fire && writes;

    assign rd.src1 = in_instr.src1;
    assign rd.src2 = in_instr.src2;
    assign rd.dest = in_instr.dest;
    assign rd.wr   = writes;

    map_table #(
        .NUM_PHYS (NUM_PHYS)
    ) u_map (
        .clk      (clk),
        .reset    (reset),
        .rd       (rd),
        .new_tag  (free_tag),
        .wr_en    (fire),
        .src1_tag (src1_tag),
        .src2_tag (src2_tag),
        .old_tag  (old_tag)
    );

    always_comb begin
        out_data.op       = in_instr.op;
        out_data.src1_tag = src1_tag;
        out_data.src2_tag = src2_tag;
        out_data.dest_tag = writes ? free_tag : '0;
        out_data.old_tag  = writes ? old_tag : '0;   // nothing to free later
    end

endmodule

// File: verilog/rename_issue.sv
`timescale 1ns/1ps

module rename_issue (
    input  logic                 clk,
    input  logic                 reset,

    // from rename_stage
    input  logic                 out_valid,
    input  rename_pkg::renamed_t out_data,
    output logic                 out_ready,

    // four-phase issue link
    output logic                 iss_req,
    output rename_pkg::renamed_t iss_out,
    input  logic                 iss_ack
);

    rename_pkg::hs_state_t state;
    logic                  load;

    assign out_ready = (state == rename_pkg::HS_IDLE);
    assign load      = out_valid && out_ready;

    // IDLE -> BUSY with req up, BUSY -> DONE once acked, DONE -> IDLE when ack drops
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rename_pkg::HS_IDLE;
        end else begin
            case (state)
                rename_pkg::HS_IDLE: if (load)     state <= rename_pkg::HS_BUSY;
                rename_pkg::HS_BUSY: if (iss_ack)  state <= rename_pkg::HS_DONE;
                rename_pkg::HS_DONE: if (!iss_ack) state <= rename_pkg::HS_IDLE;
                default:                           state <= rename_pkg::HS_IDLE;
            endcase
        end
    end

    // held stable for the whole handshake
    always_ff @(posedge clk) begin
        if (load) iss_out <= out_data;
    end

    assign iss_req = (state == rename_pkg::HS_BUSY);

endmodule

// File: verilog/rename_top.sv
`timescale 1ns/1ps

module rename_top #(
    parameter int NUM_PHYS = 48    // 33..128
) (
    input  logic                          clk,
    input  logic                          reset,

    input  logic                          dec_req,
    input  rename_pkg::arch_instr_t       dec_instr,
    output logic                          dec_ack,

    output logic                          iss_req,
    output rename_pkg::renamed_t          iss_out,
    input  logic                          iss_ack,

    input  logic                          ret_req,
    input  logic [rename_pkg::PHYS_W-1:0] ret_tag,
    output logic                          ret_ack
);

    logic                          in_valid;
    rename_pkg::arch_instr_t       in_instr;
    logic                          in_ready;
    logic                          out_valid;
    rename_pkg::renamed_t          out_data;
    logic                          out_ready;
    logic                          pop;
    logic [rename_pkg::PHYS_W-1:0] free_tag;
    logic                          empty;

    decode_intake u_intake (
        .clk       (clk),
        .reset     (reset),
        .dec_req   (dec_req),
        .dec_instr (dec_instr),
        .dec_ack   (dec_ack),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .in_ready  (in_ready)
    );

    rename_stage #(
        .NUM_PHYS (NUM_PHYS)
    ) u_stage (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready),
        .pop       (pop),
        .free_tag  (free_tag),
        .empty     (empty)
    );

    rename_issue u_issue (
        .clk       (clk),
        .reset     (reset),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready),
        .iss_req   (iss_req),
        .iss_out   (iss_out),
        .iss_ack   (iss_ack)
    );

    free_list #(
        .NUM_PHYS (NUM_PHYS)
    ) u_free (
        .clk      (clk),
        .reset    (reset),
        .pop      (pop),
        .free_tag (free_tag),
        .empty    (empty),
        .ret_req  (ret_req),
        .ret_tag  (ret_tag),
        .ret_ack  (ret_ack)
    );

endmodule

// File: bench/rename_sva.sv
`timescale 1ns/1ps

module rename_sva (
    input logic                          clk,
    input logic                          reset,
    input logic                          dec_req,
    input logic                          dec_ack,
    input rename_pkg::arch_instr_t       dec_instr,
    input logic                          iss_req,
    input logic                          iss_ack,
    input rename_pkg::renamed_t          iss_out,
    input logic                          ret_req,
    input logic                          ret_ack,
    input logic [rename_pkg::PHYS_W-1:0] ret_tag
);

    int violations = 0;

    // decode and retire masters move on the falling edge, the DUT answers on the rising one
    dec_no_early_req: assert property (@(posedge clk) disable iff (reset)
        $rose(dec_req) |-> !dec_ack)
        else begin
            $error("dec_req rose with dec_ack high");
            violations++;
        end
    dec_ack_held: assert property (@(posedge clk) disable iff (reset)
        dec_req && dec_ack |=> dec_ack)
        else begin
            $error("dec_ack fell with dec_req high");
            violations++;
        end
    dec_data_stable: assert property (@(posedge clk) disable iff (reset)
        dec_req && !dec_ack |=> $stable(dec_instr))
        else begin
            $error("dec_instr changed");
            violations++;
        end

    ret_no_early_req: assert property (@(posedge clk) disable iff (reset)
        $rose(ret_req) |-> !ret_ack)
        else begin
            $error("ret_req rose with ret_ack high");
            violations++;
        end
    ret_ack_held: assert property (@(posedge clk) disable iff (reset)
        ret_req && ret_ack |=> ret_ack)
        else begin
            $error("ret_ack fell with ret_req high");
            violations++;
        end
    ret_data_stable: assert property (@(posedge clk) disable iff (reset)
        ret_req && !ret_ack |=> $stable(ret_tag))
        else begin
            $error("ret_tag changed");
            violations++;
        end

    // issue link is the other way round, req moves on the rising edge
    iss_no_early_req: assert property (@(posedge clk) disable iff (reset)
        $rose(iss_req) |-> !$past(iss_ack))
        else begin
            $error("iss_req rose with iss_ack high");
            violations++;
        end
    iss_ack_held: assert property (@(posedge clk) disable iff (reset)
        $fell(iss_ack) |-> !iss_req)
        else begin
            $error("iss_ack fell with iss_req high");
            violations++;
        end
    iss_data_stable: assert property (@(posedge clk) disable iff (reset)
        iss_req && !iss_ack |=> $stable(iss_out))
        else begin
            $error("iss_out changed");
            violations++;
        end

endmodule

bind rename_top rename_sva u_sva (
    .clk       (clk),
    .reset     (reset),
    .dec_req   (dec_req),
    .dec_ack   (dec_ack),
    .dec_instr (dec_instr),
    .iss_req   (iss_req),
    .iss_ack   (iss_ack),
    .iss_out   (iss_out),
    .ret_req   (ret_req),
    .ret_ack   (ret_ack),
    .ret_tag   (ret_tag)
);

// File: bench/rename_tb.sv
`timescale 1ns/1ps

module rename_tb;

    localparam int NUM_PHYS   = 48;
    localparam int AW         = rename_pkg::ARCH_W;
    localparam int N_FILL     = 16;     // writes that use up the free list
    localparam int N_FLOW     = 4;      // non-writes sent while the list is empty
    localparam int N_RAND     = 300;
    localparam int N_INSTR    = N_FILL + N_FLOW + 1 + N_RAND;
    localparam int MAX_CYCLES = 200 * N_INSTR;

    typedef logic [rename_pkg::PHYS_W-1:0] tag_t;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    dec_req;
    rename_pkg::arch_instr_t dec_instr;
    logic                    dec_ack;
    logic                    iss_req;
    rename_pkg::renamed_t    iss_out;
    logic                    iss_ack;
    logic                    ret_req;
    tag_t                    ret_tag;
    logic                    ret_ack;

    // reference model
    tag_t                    model_map [rename_pkg::NUM_ARCH];
    tag_t                    free_q [$];
    tag_t                    old_q [$];     // old tags of issued writes, not yet retired
    rename_pkg::arch_instr_t sent_q [$];
    int                      issued = 0;
    int                      cycles = 0;
    bit                      ret_hold;      // retire driver stays quiet

    rename_top #(
        .NUM_PHYS (NUM_PHYS)
    ) uut (
        .clk       (clk),
        .reset     (reset),
        .dec_req   (dec_req),
        .dec_instr (dec_instr),
        .dec_ack   (dec_ack),
        .iss_req   (iss_req),
        .iss_out   (iss_out),
        .iss_ack   (iss_ack),
        .ret_req   (ret_req),
        .ret_tag   (ret_tag),
        .ret_ack   (ret_ack)
    );

    always #20 clk = ~clk;

    task automatic stop_run();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic value_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    function automatic bit is_write(input rename_pkg::arch_instr_t ins);
        return (ins.op == rename_pkg::OP_ALU || ins.op == rename_pkg::OP_LOAD) && ins.dest != '0;
    endfunction

    function automatic logic [AW-1:0] nonzero_reg();
        return AW'($urandom_range(31, 1));
    endfunction

    function automatic rename_pkg::arch_instr_t make_instr(input rename_pkg::op_t op,
                                                           input logic [AW-1:0] dest);
        rename_pkg::arch_instr_t ins;
        ins.op   = op;
        ins.src1 = AW'($urandom_range(31, 0));
        ins.src2 = AW'($urandom_range(31, 0));
        ins.dest = dest;
        return ins;
    endfunction

    // four-phase master on the decode link, called on a falling edge
    task automatic send_instr(input rename_pkg::arch_instr_t ins);
        repeat ($urandom_range(3, 0)) @(negedge clk);
        dec_instr = ins;
        dec_req   = 1'b1;
        sent_q.push_back(ins);
        @(negedge clk);
        while (!dec_ack) @(negedge clk);
        dec_req = 1'b0;
        @(negedge clk);
        while (dec_ack) @(negedge clk);
    endtask

    task automatic wait_for_issue(input int n);
        while (issued < n) @(negedge clk);
    endtask

    task automatic check_issue(input rename_pkg::renamed_t got);
        rename_pkg::arch_instr_t ins;
        tag_t                    exp_dest;
        tag_t                    exp_old;
        assert (sent_q.size() > 0) else begin
            $display("issue handshake seen with no instruction outstanding");
            stop_run();
        end
        ins      = sent_q.pop_front();
        exp_dest = '0;
        exp_old  = '0;
        if (is_write(ins)) begin
            assert (free_q.size() > 0) else begin
                $display("write issued although the model has no free tag");
                stop_run();
            end
            exp_dest = free_q.pop_front();
            exp_old  = model_map[ins.dest];
        end
        assert (got.op == ins.op)
            else value_error($sformatf("op %0d, expected %0d", got.op, ins.op));
        assert (got.src1_tag == model_map[ins.src1])
            else value_error($sformatf("src1_tag %0d, expected %0d", got.src1_tag,
                                       model_map[ins.src1]));
        assert (got.src2_tag == model_map[ins.src2])
            else value_error($sformatf("src2_tag %0d, expected %0d", got.src2_tag,
                                       model_map[ins.src2]));
        assert (got.dest_tag == exp_dest)
            else value_error($sformatf("dest_tag %0d, expected %0d", got.dest_tag, exp_dest));
        assert (got.old_tag == exp_old)
            else value_error($sformatf("old_tag %0d, expected %0d", got.old_tag, exp_old));
        if (is_write(ins)) begin
            model_map[ins.dest] = exp_dest;   // later sources see the new tag
            old_q.push_back(exp_old);
        end
        issued++;
    endtask

    // four-phase slave on the issue link with a random ack delay
    initial begin : issue_receiver
        iss_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (reset || !iss_req) continue;
            repeat ($urandom_range(4, 0)) @(negedge clk);
            check_issue(iss_out);
            iss_ack = 1'b1;
            @(negedge clk);
            while (iss_req) @(negedge clk);
            iss_ack = 1'b0;
        end
    end

    // returns old tags in issue order, now and then a tag 0
    initial begin : retire_driver
        tag_t tag;
        bit   zero;
        ret_req = 1'b0;
        ret_tag = '0;
        forever begin
            @(negedge clk);
            if (reset || ret_hold) continue;
            zero = ($urandom_range(7, 0) == 0);
            if (!zero && old_q.size() == 0) continue;
            if ($urandom_range(3, 0) != 0) continue;      // random gap
            tag     = zero ? '0 : old_q.pop_front();
            ret_tag = tag;
            ret_req = 1'b1;
            @(negedge clk);
            while (!ret_ack) @(negedge clk);
            if (tag != '0) free_q.push_back(tag);   // the free list took it at the ack edge
            ret_req = 1'b0;
            @(negedge clk);
            while (ret_ack) @(negedge clk);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles, the run hung with %0d issued", cycles, issued);
            stop_run();
        end
    end

    initial begin : main_sequence
        rename_pkg::arch_instr_t ins;
        void'($urandom(32'h080f_c588));
        reset     = 1'b1;
        dec_req   = 1'b0;
        dec_instr = '0;
        ret_hold  = 1'b1;
        for (int i = 0; i < rename_pkg::NUM_ARCH; i++) begin
            model_map[i] = tag_t'(i);
        end
        for (int t = rename_pkg::NUM_ARCH; t < NUM_PHYS; t++) begin
            free_q.push_back(tag_t'(t));
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // retires held back, 16 writes take every free tag
        for (int i = 0; i < N_FILL; i++) begin
            send_instr(make_instr(rename_pkg::OP_ALU, nonzero_reg()));
        end
        // ALU and LOAD to r0, then STORE and BRANCH
        for (int i = 0; i < N_FLOW; i++) begin
            ins = make_instr(rename_pkg::op_t'(i[1:0]), '0);
            if (i >= 2) ins.dest = nonzero_reg();
            send_instr(ins);
        end
        wait_for_issue(N_FILL + N_FLOW);
        assert (uut.u_free.empty) else begin
            $display("DUT free list not empty after the fill phase");
            stop_run();
        end

        // a write now has to wait for a retire
        send_instr(make_instr(rename_pkg::OP_LOAD, nonzero_reg()));
        repeat (20) @(negedge clk);
        assert (issued == N_FILL + N_FLOW) else begin
            $display("a write was issued while the free list was empty");
            stop_run();
        end
        ret_hold = 1'b0;
        wait_for_issue(N_FILL + N_FLOW + 1);

        for (int i = 0; i < N_RAND; i++) begin
            ins = make_instr(rename_pkg::op_t'($urandom_range(3, 0)), '0);
            if ($urandom_range(7, 0) != 0) ins.dest = nonzero_reg();
            send_instr(ins);
        end
        wait_for_issue(N_INSTR);
        while (old_q.size() != 0) @(negedge clk);
        ret_hold = 1'b1;
        while (ret_req || ret_ack) @(negedge clk);
        @(negedge clk);

        assert (int'(uut.u_free.count) == free_q.size())
            else value_error($sformatf("free list holds %0d tags, model holds %0d",
                                       uut.u_free.count, free_q.size()));
        if (uut.u_sva.violations == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("handshake protocol assertions failed %0d times", uut.u_sva.violations);
            stop_run();
        end
    end

endmodule

// File: list.f
verilog/rename_pkg.sv
verilog/decode_intake.sv
verilog/map_table.sv
verilog/free_list.sv
verilog/rename_stage.sv
verilog/rename_issue.sv
verilog/rename_top.sv
bench/rename_sva.sv
bench/rename_tb.sv

// File: Makefile
VERILATOR   := verilator
TOP         := rename_tb
LINT_TOP    := rename_top
FILELIST    := list.f
OBJ_DIR     := obj_dir
LOG         := sim.log
LINT_FLAGS  := --lint-only -Wall --timing --assert
BUILD_FLAGS := --binary --timing --assert -j 0
RUN_FLAGS   := +verilator+error+limit+1000
PASS_TEXT   := TEST PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
